// File: run_sim.sh
#!/bin/sh
# build the testbench and design with verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_soc_bus -o tb_soc_bus
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tb_soc_bus
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// File: sim.f
verilog/soc_bus_pkg.sv
verilog/bus_req_if.sv
verilog/addr_decoder.sv
verilog/req_fifo.sv
verilog/mem_responder.sv
verilog/soc_bus_top.sv
testbench/tb_soc_bus.sv

// File: testbench/tb_soc_bus.sv
`default_nettype none

module tb_soc_bus;
  import soc_bus_pkg::*;

  localparam int unsigned NumWords  = 256;
  localparam int unsigned FifoDepth = 4;
  localparam int unsigned NumTable  = 22;
  localparam int unsigned NumRandom = 60;
  localparam int unsigned NumTotal  = NumTable + NumRandom;

  typedef struct packed {
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
    data_t rdata;
    resp_e resp;
    logic  stall;
  } entry_t;

  // we, addr, be, wdata, expected rdata, expected resp, hold responses
  localparam entry_t StimTable [NumTable] = '{
    '{1'b0, 32'h0001_0000, 8'h00, 64'h0, 64'h0000_0297_0182_8293, RespOkay, 1'b0},
    '{1'b0, 32'h0001_0018, 8'h00, 64'h0, 64'h1050_0073_ffdf_f06f, RespOkay, 1'b0},
    '{1'b0, 32'h0001_0048, 8'h00, 64'h0, 64'h0202_8593_f140_2573, RespOkay, 1'b0},
    '{1'b0, 32'h0001_0ff8, 8'h00, 64'h0, 64'h0123_4567_89ab_cdef, RespOkay, 1'b0},
    '{1'b1, 32'h0001_0008, 8'hff, 64'h5555_5555_5555_5555, 64'h0, RespSlvErr, 1'b0},
    '{1'b1, 32'h8000_0010, 8'hff, 64'h1122_3344_5566_7788, 64'h0, RespOkay, 1'b0},
    '{1'b0, 32'h8000_0010, 8'h00, 64'h0, 64'h1122_3344_5566_7788, RespOkay, 1'b0},
    '{1'b1, 32'h8000_0010, 8'h0f, 64'haaaa_aaaa_bbbb_bbbb, 64'h0, RespOkay, 1'b0},
    '{1'b0, 32'h8000_0010, 8'h00, 64'h0, 64'h1122_3344_bbbb_bbbb, RespOkay, 1'b0},
    '{1'b1, 32'h8000_0018, 8'h81, 64'hffee_ddcc_bbaa_9988, 64'h0, RespOkay, 1'b0},
    '{1'b0, 32'h8000_0018, 8'h00, 64'h0, 64'hff00_0000_0000_0088, RespOkay, 1'b0},
    '{1'b0, 32'h4000_0000, 8'h00, 64'h0, 64'h0, RespSlvErr, 1'b0},
    '{1'b1, 32'h4000_0100, 8'hff, 64'h1234_5678_9abc_def0, 64'h0, RespSlvErr, 1'b0},
    '{1'b0, 32'h2000_0000, 8'h00, 64'h0, 64'h0, RespDecErr, 1'b0},
    '{1'b0, 32'h8000_0800, 8'h00, 64'h0, 64'h0, RespDecErr, 1'b0},
    // back-pressure burst
    '{1'b0, 32'h0001_0020, 8'h00, 64'h0, 64'h8000_0000_0000_0000, RespOkay, 1'b1},
    '{1'b0, 32'h8000_0010, 8'h00, 64'h0, 64'h1122_3344_bbbb_bbbb, RespOkay, 1'b1},
    '{1'b0, 32'h0001_0028, 8'h00, 64'h0, 64'h0001_0040_0000_0000, RespOkay, 1'b1},
    '{1'b0, 32'h8000_0018, 8'h00, 64'h0, 64'hff00_0000_0000_0088, RespOkay, 1'b1},
    '{1'b0, 32'h0001_0030, 8'h00, 64'h0, 64'hdead_beef_cafe_f00d, RespOkay, 1'b1},
    '{1'b0, 32'h9000_0000, 8'h00, 64'h0, 64'h0, RespDecErr, 1'b1},
    '{1'b0, 32'h8000_07f8, 8'h00, 64'h0, 64'h0, RespOkay, 1'b1}
  };

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  req_valid_i;
  logic  req_ready_o;
  logic  req_we_i;
  addr_t req_addr_i;
  be_t   req_be_i;
  data_t req_wdata_i;
  logic  resp_valid_o;
  logic  resp_ready_i;
  data_t resp_rdata_o;
  resp_e resp_err_o;

  logic [31:0] rng_state = 32'd9966;
  data_t       ram_model [NumWords];
  entry_t      exp_q [$];

  soc_bus_top #(
    .NumWords     ( NumWords     ),
    .FifoDepth    ( FifoDepth    )
  ) u_dut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_be_i     ( req_be_i     ),
    .req_wdata_i  ( req_wdata_i  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_rdata_o ( resp_rdata_o ),
    .resp_err_o   ( resp_err_o   )
  );

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // model and helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic in_ram(input addr_t a);
    return (a >= DramBase) && ((a - DramBase) < addr_t'(NumWords * 8));
  endfunction

  task automatic apply_write(input entry_t req);
    for (int b = 0; b < BeWidth; b++) begin
      if (req.be[b]) begin
        ram_model[(req.addr - DramBase) >> 3][8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
  endtask

  // ram request within the first sixteen words
  task automatic random_request(output entry_t req);
    rng_state = xorshift(rng_state);
    req.we    = rng_state[0];
    req.addr  = DramBase + addr_t'({rng_state[7:4], 3'b000});
    req.be    = rng_state[15:8];
    rng_state = xorshift(rng_state);
    req.wdata = {rng_state, ~rng_state};
    req.rdata = '0;
    req.resp  = RespOkay;
    req.stall = 1'b0;
  endtask

  task automatic check_rdata(input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t resp_rdata_o got %h expected %h", $time, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_resp(input resp_e got, input resp_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t resp_err_o got %b expected %b", $time, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "response code mismatch");
    end
  endtask

  // ----------------------------------------
  // stimulus and response checking
  // ----------------------------------------
  initial begin : drive_and_check
    entry_t cur;
    entry_t exp_e;
    int     issued;
    int     done;
    logic   saw_full;
    issued       = 0;
    done         = 0;
    saw_full     = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_be_i     = '0;
    req_wdata_i  = '0;
    resp_ready_i = 1'b0;
    for (int i = 0; i < NumWords; i++) begin
      ram_model[i] = '0;
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    if (req_ready_o !== 1'b1 || resp_valid_o !== 1'b0) begin
      $display("RESULT: FAIL");
      $fatal(1, "bus not idle after reset");
    end
    cur = StimTable[0];
    while (done < NumTotal) begin
      @(negedge clk_i);
      req_valid_i = (issued < NumTotal);
      req_we_i    = cur.we;
      req_addr_i  = cur.addr;
      req_be_i    = cur.be;
      req_wdata_i = cur.wdata;
      if (issued < NumTotal && cur.stall && !saw_full) begin
        resp_ready_i = 1'b0;
      end else if (issued < NumTable) begin
        resp_ready_i = 1'b1;
      end else begin
        rng_state    = xorshift(rng_state);
        resp_ready_i = rng_state[0] | rng_state[1];
      end
      // let combinational ready settle before sampling
      #1;
      if (resp_valid_o && resp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("RESULT: FAIL");
          $fatal(1, "response arrived with no request outstanding");
        end
        exp_e = exp_q.pop_front();
        check_rdata(resp_rdata_o, exp_e.rdata);
        check_resp(resp_err_o, exp_e.resp);
        done++;
      end
      if (cur.stall && req_valid_i && !req_ready_o && !resp_ready_i) begin
        // fifo entries plus the held response
        if (exp_q.size() != FifoDepth + 1) begin
          $display("RESULT: FAIL");
          $fatal(1, "request ready dropped with the wrong number of requests outstanding");
        end
        saw_full = 1'b1;
      end
      if (req_valid_i && req_ready_o) begin
        if (issued >= NumTable && !cur.we) begin
          cur.rdata = ram_model[(cur.addr - DramBase) >> 3];
        end
        if (cur.we && in_ram(cur.addr)) begin
          apply_write(cur);
        end
        exp_q.push_back(cur);
        issued++;
        if (issued < NumTable) begin
          cur = StimTable[issued];
        end else if (issued < NumTotal) begin
          random_request(cur);
        end
      end
    end
    if (!saw_full) begin
      $display("RESULT: FAIL");
      $fatal(1, "request ready never dropped while responses were held");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  initial begin : watchdog
    #((NumTotal * 40 + 5) * 40);
    $display("RESULT: FAIL");
    $fatal(1, "timeout, not all responses arrived");
  end

endmodule

`default_nettype wire

// File: verilog/addr_decoder.sv
`default_nettype none

module addr_decoder #(
  parameter int unsigned NumWords = 256
) (
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                req_we_i,
  input  soc_bus_pkg::addr_t  req_addr_i,
  input  soc_bus_pkg::be_t    req_be_i,
  input  soc_bus_pkg::data_t  req_wdata_i,
  bus_req_if.src              dec_o
);
  import soc_bus_pkg::*;

  localparam addr_t DramLength = addr_t'(NumWords * BeWidth);

  logic    in_rom;
  logic    in_gpio;
  logic    in_dram;
  target_e target;

  // ----------------------------------------
  // window match
  // ----------------------------------------
  assign in_rom  = (req_addr_i >= RomBase) && (req_addr_i < RomBase + RomLength);
  assign in_gpio = (req_addr_i >= GpioBase) && (req_addr_i < GpioBase + GpioLength);
  // offset compare avoids overflow at the top of the ram window
  assign in_dram = (req_addr_i >= DramBase) && ((req_addr_i - DramBase) < DramLength);

  always_comb begin
    if (in_rom) begin
      target = TgtRom;
    end else if (in_gpio) begin
      target = TgtGpio;
    end else if (in_dram) begin
      target = TgtDram;
    end else begin
      // unclaimed addresses go to the error target
      target = TgtNone;
    end
  end

  // ----------------------------------------
  // handshake pass-through
  // ----------------------------------------
  assign dec_o.valid          = req_valid_i;
  assign dec_o.payload.we     = req_we_i;
  assign dec_o.payload.addr   = req_addr_i;
  assign dec_o.payload.be     = req_be_i;
  assign dec_o.payload.wdata  = req_wdata_i;
  assign dec_o.payload.target = target;

  assign req_ready_o = dec_o.ready;

endmodule

`default_nettype wire

// File: verilog/bus_req_if.sv
`default_nettype none

// one decoded request travelling between two blocks
interface bus_req_if;
  import soc_bus_pkg::*;

  // transfer on a rising edge with valid and ready both high
  logic     valid;
  logic     ready;
  bus_req_t payload;

  // sending side holds valid and payload until taken
  modport src (
    output valid,
    output payload,
    input  ready
  );

  // receiving side
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// File: verilog/mem_responder.sv
`default_nettype none

module mem_responder #(
  parameter int unsigned NumWords = 256
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  bus_req_if.sink            req_i,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output soc_bus_pkg::data_t resp_rdata_o,
  output soc_bus_pkg::resp_e resp_err_o
);
  import soc_bus_pkg::*;

  localparam int unsigned IdxWidth    = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam int unsigned OffWidth    = $clog2(BeWidth);
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  data_t                  ram_q [NumWords];
  logic                   resp_valid_q;
  data_t                  rdata_q;
  data_t                  rdata_d;
  resp_e                  err_q;
  resp_e                  err_d;
  logic                   pop;
  logic                   ram_wr;
  addr_t                  dram_off;
  addr_t                  rom_off;
  logic [IdxWidth-1:0]    ram_idx;
  logic [RomIdxWidth-1:0] rom_idx;

  // take the next request when the slot is empty or being drained
  assign req_i.ready = !resp_valid_q || resp_ready_i;
  assign pop         = req_i.valid && req_i.ready;

  assign dram_off = req_i.payload.addr - DramBase;
  assign rom_off  = req_i.payload.addr - RomBase;
  assign ram_idx  = dram_off[IdxWidth+OffWidth-1:OffWidth];
  assign rom_idx  = rom_off[RomIdxWidth+OffWidth-1:OffWidth];
  assign ram_wr   = pop && req_i.payload.we && (req_i.payload.target == TgtDram);

  // ----------------------------------------
  // response select per target
  // ----------------------------------------
  always_comb begin
    rdata_d = '0;
    err_d   = RespOkay;
    case (req_i.payload.target)
      TgtDram: begin
        if (!req_i.payload.we) begin
          rdata_d = ram_q[ram_idx];
        end
      end
      TgtRom: begin
        // rom is read only
        if (req_i.payload.we) begin
          err_d = RespSlvErr;
        end else begin
          rdata_d = RomImage[rom_idx];
        end
      end
      TgtGpio: err_d = RespSlvErr;
      default: err_d = RespDecErr;
    endcase
  end

  // response slot holds until taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      rdata_q      <= '0;
      err_q        <= RespOkay;
    end else if (pop) begin
      resp_valid_q <= 1'b1;
      rdata_q      <= rdata_d;
      err_q        <= err_d;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // ram with byte enables
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumWords; i++) begin
        ram_q[i] <= '0;
      end
    end else if (ram_wr) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (req_i.payload.be[b]) begin
          ram_q[ram_idx][8*b +: 8] <= req_i.payload.wdata[8*b +: 8];
        end
      end
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_rdata_o = rdata_q;
  assign resp_err_o   = err_q;

endmodule

`default_nettype wire

// File: verilog/req_fifo.sv
`default_nettype none

module req_fifo #(
  parameter int unsigned Depth     = 4,
  parameter type         payload_t = soc_bus_pkg::bus_req_t
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  bus_req_if.sink in_i,
  bus_req_if.src  out_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full;
  logic                push;
  logic                pop;

  // wrap for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count_q == CntWidth'(Depth));
  // when full, a pop in the same cycle frees a slot
  assign in_i.ready    = !full || out_o.ready;
  assign out_o.valid   = (count_q != '0);
  assign out_o.payload = mem_q[rd_ptr_q];

  assign push = in_i.valid && in_i.ready;
  assign pop  = out_o.valid && out_o.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CntWidth'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CntWidth'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i.payload;
    end
  end

endmodule

`default_nettype wire

// File: verilog/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam addr_t RomBase    = 32'h0001_0000;
  localparam addr_t RomLength  = 32'h0000_1000;
  localparam addr_t GpioBase   = 32'h4000_0000;
  localparam addr_t GpioLength = 32'h0000_1000;
  // ram length comes from the word count at the top level
  localparam addr_t DramBase   = 32'h8000_0000;

  // boot rom contents repeat over the whole rom window
  localparam int unsigned RomWords = 8;
  localparam data_t RomImage [RomWords] = '{
    64'h0000_0297_0182_8293,
    64'h0202_8593_f140_2573,
    64'h0005_8067_0000_0000,
    64'h1050_0073_ffdf_f06f,
    64'h8000_0000_0000_0000,
    64'h0001_0040_0000_0000,
    64'hdead_beef_cafe_f00d,
    64'h0123_4567_89ab_cdef
  };

  typedef enum logic [1:0] {
    TgtRom,
    TgtDram,
    TgtGpio,
    TgtNone
  } target_e;

  // same codes as the axi response field
  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10,
    RespDecErr = 2'b11
  } resp_e;

  typedef struct packed {
    logic    we;
    addr_t   addr;
    be_t     be;
    data_t   wdata;
    target_e target;
  } bus_req_t;

endpackage

`default_nettype wire

// File: verilog/soc_bus_top.sv
`default_nettype none

module soc_bus_top #(
  parameter int unsigned NumWords  = 256,
  parameter int unsigned FifoDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // request side
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic               req_we_i,
  input  soc_bus_pkg::addr_t req_addr_i,
  input  soc_bus_pkg::be_t   req_be_i,
  input  soc_bus_pkg::data_t req_wdata_i,
  // response side
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output soc_bus_pkg::data_t resp_rdata_o,
  output soc_bus_pkg::resp_e resp_err_o
);
  import soc_bus_pkg::*;

  bus_req_if dec_if ();
  bus_req_if mem_if ();

  // ----------------------------------------
  // decode, buffer, serve
  // ----------------------------------------
  addr_decoder #(
    .NumWords    ( NumWords    )
  ) u_addr_decoder (
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_be_i    ( req_be_i    ),
    .req_wdata_i ( req_wdata_i ),
    .dec_o       ( dec_if      )
  );

  req_fifo #(
    .Depth     ( FifoDepth ),
    .payload_t ( bus_req_t )
  ) u_req_fifo (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .in_i      ( dec_if    ),
    .out_o     ( mem_if    )
  );

  mem_responder #(
    .NumWords     ( NumWords     )
  ) u_mem_responder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( mem_if       ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_rdata_o ( resp_rdata_o ),
    .resp_err_o   ( resp_err_o   )
  );

endmodule

`default_nettype wire
